// ==== src/cpuPkg.sv ====
package cpuPkg;

    ////////////////////////////////////////////////////////////
    // Widths and sizes

    localparam int dataWidth     = 8;    // Data, instructions
    localparam int addrWidth     = 8;    // Program and data RAM addresses
    localparam int hostAddrWidth = 9;    // Top bit selects program memory
    localparam int ramDepth      = 256;  // Words in data RAM and program memory

    typedef logic [dataWidth-1:0] byteT;

    // Program addresses that hold each thread's start address
    localparam byteT vectorLine0 = 8'hFF;
    localparam byteT vectorLine1 = 8'hFE;

    ////////////////////////////////////////////////////////////
    // Instruction fields

    // Low nibble of the instruction byte
    typedef enum logic [3:0] {
        opReadA  = 4'h0, opReadB  = 4'h1,
        opWriteA = 4'h2, opWriteB = 4'h3,
        opAluA   = 4'h4, opAluB   = 4'h5,
        opBranch = 4'h6, opGoto   = 4'h7,
        opIdle   = 4'h8, opCall   = 4'h9,
        opReturn = 4'hA,
        opDerefA = 4'hB, opDerefB = 4'hC
    } opcodeT;

    // High nibble of the instruction byte
    typedef enum logic [3:0] {
        aluAdd  = 4'h0, aluSub  = 4'h1, aluMul  = 4'h2,
        aluShl  = 4'h3, aluShr  = 4'h4,
        aluIncA = 4'h5, aluIncB = 4'h6,
        aluDecA = 4'h7, aluDecB = 4'h8,
        aluEq   = 4'h9, aluGt   = 4'hA, aluLt   = 4'hB
    } aluOpT;

    typedef enum logic [3:0] {
        stIdle, stVector, stVectorLoad, stFetch, stDecode,
        stBusSetup, stBusAccess, stRegLoad, stJump, stReturn
    } coreStateT;

endpackage

// ==== src/memBusIf.sv ====
`timescale 1ns/100ps

// APB-style data bus between requesters and the data RAM
interface memBusIf;
    import cpuPkg::*;

    logic                 sel;     // Transfer in progress
    logic                 enable;  // Access phase
    logic                 write;
    logic [addrWidth-1:0] addr;
    byteT                 wData;
    byteT                 rData;   // Valid while ready is high
    logic                 ready;   // Ends the access phase

    // Side that starts transfers
    modport requester (
        output sel, enable, write, addr, wData,
        input  rData, ready
    );

    // Side that answers them
    modport completer (
        input  sel, enable, write, addr, wData,
        output rData, ready
    );

endinterface

// ==== src/aluUnit.sv ====
`timescale 1ns/100ps

module aluUnit (
    input  logic [cpuPkg::dataWidth-1:0] a,
    input  logic [cpuPkg::dataWidth-1:0] b,
    input  cpuPkg::aluOpT                op,
    output logic [cpuPkg::dataWidth-1:0] result
);
    import cpuPkg::*;

    // Purely combinational, result is read in the decode cycle
    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluMul:  result = a * b;            // Low byte only
            aluShl:  result = a << 1;
            aluShr:  result = a >> 1;
            aluIncA: result = a + 8'd1;
            aluIncB: result = b + 8'd1;
            aluDecA: result = a - 8'd1;
            aluDecB: result = b - 8'd1;

            // Compares give 1 or 0, used by branch
            aluEq:   result = byteT'(a == b);
            aluGt:   result = byteT'(a > b);
            aluLt:   result = byteT'(a < b);
            default: result = '0;               // Unused codes
        endcase
    end

endmodule

// ==== src/cpuCore.sv ====
`timescale 1ns/100ps

module cpuCore (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic [1:0]                   irqRaise,
    input  logic [cpuPkg::dataWidth-1:0] progData,   // One cycle after progAddr
    output logic [cpuPkg::addrWidth-1:0] progAddr,
    output logic [1:0]                   irqAck,
    output logic                         threadActive,
    memBusIf.requester                   bus
);
    import cpuPkg::*;

    coreStateT state;
    byteT      pc;
    byteT      regA;
    byteT      regB;
    byteT      progContext;  // Return address of the one open call
    opcodeT    curOp;        // Bus instruction being executed
    opcodeT    decOp;
    byteT      aluResult;
    byteT      setupAddr;
    byteT      addrHold;     // Address kept through the access phase
    byteT      loadData;     // Bus read data on its way to A or B
    logic      isDeref;
    logic      isWrite;
    logic      useB;

    ////////////////////////////////////////////////////////////
    // Decode helpers

    assign decOp   = opcodeT'(progData[3:0]);  // Valid in stDecode only
    assign isDeref = (curOp == opDerefA) || (curOp == opDerefB);
    assign isWrite = (curOp == opWriteA) || (curOp == opWriteB);
    assign useB    = (curOp == opReadB) || (curOp == opWriteB) || (curOp == opDerefB);

    // ALU sees the instruction byte directly while decoding
    aluUnit alu0 (
        .a      (regA),
        .b      (regB),
        .op     (aluOpT'(progData[7:4])),
        .result (aluResult)
    );

    // Decode presents the operand address so it arrives one state later
    assign progAddr = (state == stDecode) ? pc + 8'd1 : pc;

    ////////////////////////////////////////////////////////////
    // Data bus, phases follow the state

    // Operand byte for read/write, register value for dereference
    assign setupAddr = isDeref ? (useB ? regB : regA) : progData;

    assign bus.sel    = (state == stBusSetup) || (state == stBusAccess);
    assign bus.enable = (state == stBusAccess);
    assign bus.write  = isWrite;                       // Either register
    assign bus.addr   = (state == stBusSetup) ? setupAddr : addrHold;
    assign bus.wData  = useB ? regB : regA;

    always_ff @(posedge CLK) begin
        if (state == stBusSetup)
            addrHold <= setupAddr;
        if ((state == stBusAccess) && bus.ready)
            loadData <= bus.rData;
    end

    ////////////////////////////////////////////////////////////
    // Main FSM

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state        <= stIdle;
            pc           <= '0;
            regA         <= '0;
            regB         <= '0;
            progContext  <= '0;
            curOp        <= opIdle;
            irqAck       <= 2'b00;
            threadActive <= 1'b0;
        end else begin
            irqAck <= 2'b00;                           // Ack is a single pulse
            case (state)
                stIdle: begin
                    // Line 0 wins when both are raised
                    if (irqRaise[0]) begin
                        pc           <= vectorLine0;
                        irqAck       <= 2'b01;
                        threadActive <= 1'b1;
                        state        <= stVector;
                    end else if (irqRaise[1]) begin
                        pc           <= vectorLine1;
                        irqAck       <= 2'b10;
                        threadActive <= 1'b1;
                        state        <= stVector;
                    end
                end

                stVector: state <= stVectorLoad;       // Vector byte in flight

                stVectorLoad: begin
                    pc    <= progData;                 // Thread start address
                    state <= stFetch;
                end

                stFetch: state <= stDecode;            // Instruction byte in flight

                stDecode: begin
                    curOp <= decOp;
                    case (decOp)
                        opReadA, opReadB, opWriteA, opWriteB, opDerefA, opDerefB:
                            state <= stBusSetup;

                        opAluA: begin
                            regA  <= aluResult;
                            pc    <= pc + 8'd1;
                            state <= stFetch;
                        end

                        opAluB: begin
                            regB  <= aluResult;
                            pc    <= pc + 8'd1;
                            state <= stFetch;
                        end

                        opBranch: begin
                            if (aluResult != '0) begin
                                state <= stJump;
                            end else begin
                                pc    <= pc + 8'd2;    // Skip the operand
                                state <= stFetch;
                            end
                        end

                        opGoto: state <= stJump;

                        opCall: begin
                            progContext <= pc + 8'd2;  // Instruction after the call
                            state       <= stJump;
                        end

                        opReturn: state <= stReturn;

                        // opIdle and the unused codes end the thread
                        default: begin
                            threadActive <= 1'b0;
                            state        <= stIdle;
                        end
                    endcase
                end

                stBusSetup: state <= stBusAccess;

                stBusAccess: begin
                    if (bus.ready)                     // Stretches while not granted
                        state <= stRegLoad;
                end

                stRegLoad: begin
                    if (!isWrite) begin
                        if (useB)
                            regB <= loadData;
                        else
                            regA <= loadData;
                    end
                    pc    <= isDeref ? pc + 8'd1 : pc + 8'd2;
                    state <= stFetch;
                end

                stJump: begin
                    pc    <= progData;                 // Operand is the target
                    state <= stFetch;
                end

                stReturn: begin
                    pc    <= progContext;
                    state <= stFetch;
                end

                default: state <= stIdle;
            endcase
        end
    end

endmodule

// ==== src/hostPort.sv ====
`timescale 1ns/100ps

module hostPort (
    input  logic                             CLK,
    input  logic                             RESET,
    input  logic                             pSel,
    input  logic                             pEnable,
    input  logic                             pWrite,
    input  logic [cpuPkg::hostAddrWidth-1:0] pAddr,
    input  logic [cpuPkg::dataWidth-1:0]     pWData,
    output logic [cpuPkg::dataWidth-1:0]     pRData,
    output logic                             pReady,
    output logic                             progWe,
    output logic [cpuPkg::addrWidth-1:0]     progWAddr,
    output logic [cpuPkg::dataWidth-1:0]     progWData,
    memBusIf.requester                       bus
);
    import cpuPkg::*;

    logic progHit;     // Access targets program memory
    logic progAccess;  // Program memory access phase

    assign progHit    = pAddr[hostAddrWidth-1];
    assign progAccess = pSel && pEnable && progHit;

    // Data RAM side rides the shared bus, phases map one to one
    assign bus.sel    = pSel && !progHit;
    assign bus.enable = pEnable && !progHit;
    assign bus.write  = pWrite;
    assign bus.addr   = pAddr[addrWidth-1:0];
    assign bus.wData  = pWData;

    // Program memory answers at once, reads return 00
    assign pReady = progHit ? progAccess : bus.ready;
    assign pRData = progHit ? '0 : bus.rData;

    // Program write strobe lands the cycle after the access phase
    always_ff @(posedge CLK) begin
        if (RESET)
            progWe <= 1'b0;
        else
            progWe <= progAccess && pWrite;
    end

    always_ff @(posedge CLK) begin
        if (progAccess && pWrite) begin
            progWAddr <= pAddr[addrWidth-1:0];
            progWData <= pWData;
        end
    end

endmodule

// ==== src/busArbiter.sv ====
`timescale 1ns/100ps

module busArbiter (
    input  logic       CLK,
    input  logic       RESET,
    memBusIf.completer coreBus,
    memBusIf.completer hostBus,
    memBusIf.requester ramBus
);
    logic grantHost;  // Host owns the RAM this cycle
    logic curHost;    // Owner while locked
    logic lastHost;   // Owner of the last finished transfer
    logic locked;     // Transfer started, hold until ready

    // Alternate on contention, otherwise give it to whoever asks
    always_comb begin
        if (locked)
            grantHost = curHost;
        else if (coreBus.sel && hostBus.sel)
            grantHost = !lastHost;
        else
            grantHost = hostBus.sel;
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            locked   <= 1'b0;
            curHost  <= 1'b0;
            lastHost <= 1'b1;                 // Core goes first after reset
        end else if (ramBus.ready) begin
            locked   <= 1'b0;
            lastHost <= grantHost;
        end else if (ramBus.sel) begin
            locked   <= 1'b1;
            curHost  <= grantHost;
        end
    end

    // Steer the granted side onto the RAM
    assign ramBus.sel    = grantHost ? hostBus.sel    : coreBus.sel;
    assign ramBus.enable = grantHost ? hostBus.enable : coreBus.enable;
    assign ramBus.write  = grantHost ? hostBus.write  : coreBus.write;
    assign ramBus.addr   = grantHost ? hostBus.addr   : coreBus.addr;
    assign ramBus.wData  = grantHost ? hostBus.wData  : coreBus.wData;

    // Waiting side sees ready low and stretches its access phase
    assign coreBus.ready = !grantHost && ramBus.ready;
    assign hostBus.ready = grantHost && ramBus.ready;
    assign coreBus.rData = grantHost ? '0 : ramBus.rData;
    assign hostBus.rData = grantHost ? ramBus.rData : '0;

endmodule

// ==== src/dataRam.sv ====
`timescale 1ns/100ps

module dataRam (
    input  logic       CLK,
    input  logic       RESET,
    memBusIf.completer bus
);
    import cpuPkg::*;

    byteT mem [0:ramDepth-1];
    byteT readReg;   // Read data captured in the first access cycle
    logic waitDone;  // First access cycle has passed

    // Ready in the second access cycle
    assign bus.ready = bus.sel && bus.enable && waitDone;
    assign bus.rData = readReg;

    always_ff @(posedge CLK) begin
        if (RESET)
            waitDone <= 1'b0;
        else if (bus.ready)
            waitDone <= 1'b0;                 // Next transfer waits again
        else if (bus.sel && bus.enable)
            waitDone <= 1'b1;
    end

    always_ff @(posedge CLK) begin
        if (bus.sel && bus.enable && !waitDone)
            readReg <= mem[bus.addr];
        if (bus.ready && bus.write)
            mem[bus.addr] <= bus.wData;       // Write on the closing edge
    end

endmodule

// ==== src/progMem.sv ====
`timescale 1ns/100ps

module progMem (
    input  logic                         CLK,
    input  logic                         we,
    input  logic [cpuPkg::addrWidth-1:0] wAddr,
    input  logic [cpuPkg::dataWidth-1:0] wData,
    input  logic [cpuPkg::addrWidth-1:0] rAddr,
    output logic [cpuPkg::dataWidth-1:0] rData
);
    import cpuPkg::*;

    byteT mem [0:ramDepth-1];  // Program image, loaded by the host

    // Host write port
    always_ff @(posedge CLK) begin
        if (we)
            mem[wAddr] <= wData;
    end

    // Core read port, one cycle latency
    always_ff @(posedge CLK) begin
        rData <= mem[rAddr];
    end

endmodule

// ==== src/cpuSystem.sv ====
`timescale 1ns/100ps

module cpuSystem (
    input  logic                             CLK,
    input  logic                             RESET,
    input  logic                             pSel,
    input  logic                             pEnable,
    input  logic                             pWrite,
    input  logic [cpuPkg::hostAddrWidth-1:0] pAddr,
    input  logic [cpuPkg::dataWidth-1:0]     pWData,
    input  logic [1:0]                       irqRaise,
    output logic [cpuPkg::dataWidth-1:0]     pRData,
    output logic                             pReady,
    output logic [1:0]                       irqAck,
    output logic                             threadActive
);
    import cpuPkg::*;

    logic [addrWidth-1:0] progAddr;
    byteT                 progData;
    logic                 progWe;
    logic [addrWidth-1:0] progWAddr;
    byteT                 progWData;

    memBusIf coreBus ();  // Core to arbiter
    memBusIf hostBus ();  // Host port to arbiter
    memBusIf ramBus ();   // Arbiter to data RAM

    cpuCore core0 (
        .CLK          (CLK),
        .RESET        (RESET),
        .irqRaise     (irqRaise),
        .progData     (progData),
        .progAddr     (progAddr),
        .irqAck       (irqAck),
        .threadActive (threadActive),
        .bus          (coreBus)
    );

    hostPort host0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .pSel      (pSel),
        .pEnable   (pEnable),
        .pWrite    (pWrite),
        .pAddr     (pAddr),
        .pWData    (pWData),
        .pRData    (pRData),
        .pReady    (pReady),
        .progWe    (progWe),
        .progWAddr (progWAddr),
        .progWData (progWData),
        .bus       (hostBus)
    );

    busArbiter arb0 (
        .CLK     (CLK),
        .RESET   (RESET),
        .coreBus (coreBus),
        .hostBus (hostBus),
        .ramBus  (ramBus)
    );

    dataRam ram0 (
        .CLK   (CLK),
        .RESET (RESET),
        .bus   (ramBus)
    );

    progMem rom0 (
        .CLK   (CLK),
        .we    (progWe),
        .wAddr (progWAddr),
        .wData (progWData),
        .rAddr (progAddr),
        .rData (progData)
    );

endmodule

// ==== testbench/tbModel.svh ====
`ifndef tbModelSvh
`define tbModelSvh

////////////////////////////////////////////////////////////
// Reference model of the instruction set

localparam int stepLimit = 200;    // Longest thread any test runs

typedef byteT memImgT [0:255];     // Program or data RAM image

int   dataErrors  = 0;
int   ackErrors   = 0;
int   otherErrors = 0;

// Model registers, they live across threads like the core's
byteT mA   = '0;
byteT mB   = '0;
byteT mCtx = '0;

// Result of the high nibble operation, from the operation table
function automatic byteT aluRef(input logic [3:0] f, input byteT a, input byteT b);
    case (f)
        aluAdd:  return a + b;
        aluSub:  return a - b;
        aluMul:  return a * b;                  // Truncated to the low byte
        aluShl:  return {a[6:0], 1'b0};
        aluShr:  return {1'b0, a[7:1]};
        aluIncA: return a + 8'd1;
        aluIncB: return b + 8'd1;
        aluDecA: return a - 8'd1;
        aluDecB: return b - 8'd1;
        aluEq:   return (a == b) ? 8'd1 : 8'd0;
        aluGt:   return (a > b) ? 8'd1 : 8'd0;
        aluLt:   return (a < b) ? 8'd1 : 8'd0;
        default: return 8'd0;
    endcase
endfunction

// Runs one thread from its vector, gives back the RAM it leaves
function automatic memImgT runIsa(input memImgT prog, input memImgT ramIn, input byteT vector);
    memImgT ram;
    byteT   pc;
    byteT   ins;
    byteT   arg;
    int     steps;
    logic   running;
    ram     = ramIn;
    pc      = prog[vector];                     // Thread start address
    running = 1'b1;
    steps   = 0;
    while (running && steps < stepLimit) begin
        ins = prog[pc];
        arg = prog[byteT'(pc + 8'd1)];          // Operand byte, if any
        steps++;
        case (ins[3:0])
            opReadA: begin
                mA = ram[arg];
                pc = pc + 8'd2;
            end
            opReadB: begin
                mB = ram[arg];
                pc = pc + 8'd2;
            end
            opWriteA: begin
                ram[arg] = mA;
                pc       = pc + 8'd2;
            end
            opWriteB: begin
                ram[arg] = mB;
                pc       = pc + 8'd2;
            end
            opAluA: begin
                mA = aluRef(ins[7:4], mA, mB);
                pc = pc + 8'd1;
            end
            opAluB: begin
                mB = aluRef(ins[7:4], mA, mB);
                pc = pc + 8'd1;
            end
            opBranch: begin
                if (aluRef(ins[7:4], mA, mB) != 8'd0)
                    pc = arg;                   // Taken on nonzero
                else
                    pc = pc + 8'd2;
            end
            opGoto:   pc = arg;
            opCall: begin
                mCtx = pc + 8'd2;               // One saved context
                pc   = arg;
            end
            opReturn: pc = mCtx;
            opDerefA: begin
                mA = ram[mA];
                pc = pc + 8'd1;
            end
            opDerefB: begin
                mB = ram[mB];
                pc = pc + 8'd1;
            end
            default:  running = 1'b0;           // Idle and unused codes
        endcase
    end
    if (running) begin
        $display("Reference model did not reach idle within %0d steps", stepLimit);
        otherErrors++;
    end
    return ram;
endfunction

////////////////////////////////////////////////////////////
// Compare tasks

task automatic checkByte(input string name, input byteT expected, input byteT actual);
    if (actual !== expected) begin
        dataErrors++;
        $display("** Error %s: expected %02h, actual %02h", name, expected, actual);
    end
endtask

task automatic checkAck(input string name, input logic [1:0] expected,
                        input logic [1:0] actual);
    if (actual !== expected) begin
        ackErrors++;
        $display("** Error %s: expected ack %b, actual ack %b", name, expected, actual);
    end
endtask

`endif

// ==== testbench/tbCpuSystem.sv ====
`timescale 1ns/100ps

module tbCpuSystem;
    import cpuPkg::*;

    // Each test loads 64 RAM bytes, 130 program bytes and reads 64 back, about
    // 1100 cycles, six threads stay far below that, 20000 leaves wide margin
    localparam int maxCycles   = 20000;
    localparam int threadLimit = 2000;   // Cycles a thread may take to go idle
    localparam int window      = 64;     // RAM bytes each test fills and checks
    localparam int progSpan    = 128;    // Program bytes loaded per test

    logic                     CLK;
    logic                     RESET;
    logic                     pSel;
    logic                     pEnable;
    logic                     pWrite;
    logic [hostAddrWidth-1:0] pAddr;
    byteT                     pWData;
    logic [1:0]               irqRaise;
    byteT                     pRData;
    logic                     pReady;
    logic [1:0]               irqAck;
    logic                     threadActive;

    int cycles    = 0;
    int ackPulses = 0;   // Cycles with an ack seen during the current thread

    `include "tbModel.svh"

    memImgT progImg;     // Program image, what the host loads
    memImgT ramExp;      // Expected data RAM
    byteT   asmPc;       // Next program byte to emit

    cpuSystem dut0 (
        .CLK          (CLK),
        .RESET        (RESET),
        .pSel         (pSel),
        .pEnable      (pEnable),
        .pWrite       (pWrite),
        .pAddr        (pAddr),
        .pWData       (pWData),
        .irqRaise     (irqRaise),
        .pRData       (pRData),
        .pReady       (pReady),
        .irqAck       (irqAck),
        .threadActive (threadActive)
    );

    always #5 CLK = ~CLK;   // 10 ns period

    // Cycle counter, stops a hung run
    always @(posedge CLK) begin
        cycles++;
        if (cycles >= maxCycles) begin
            $display("Timeout, run still going after %0d cycles", maxCycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    always @(negedge CLK) begin
        if (irqAck != 2'b00)
            ackPulses++;
    end

    ////////////////////////////////////////////////////////////
    // APB host

    task automatic apbAccess(input logic wr, input logic [hostAddrWidth-1:0] addr,
                             input byteT data, output byteT rd);
        @(posedge CLK);
        #1;
        pSel    = 1'b1;              // Setup phase
        pEnable = 1'b0;
        pWrite  = wr;
        pAddr   = addr;
        pWData  = data;
        @(posedge CLK);
        #1;
        pEnable = 1'b1;              // Access phase, held until pReady
        @(negedge CLK);
        while (!pReady)
            @(negedge CLK);
        rd = pRData;
        @(posedge CLK);              // Transfer ends on this edge
        #1;
        pSel    = 1'b0;
        pEnable = 1'b0;
    endtask

    task automatic apbWrite(input logic [hostAddrWidth-1:0] addr, input byteT data);
        byteT unused;
        apbAccess(1'b1, addr, data, unused);
    endtask

    task automatic apbRead(input logic [hostAddrWidth-1:0] addr, output byteT data);
        apbAccess(1'b0, addr, 8'h00, data);
    endtask

    ////////////////////////////////////////////////////////////
    // Program building and memory loading

    task automatic newProgram();
        foreach (progImg[i])
            progImg[i] = {4'h0, opIdle};     // Runaway code ends the thread
        asmPc = 8'h00;
    endtask

    task automatic emitOp(input opcodeT op, input logic [3:0] f = 4'h0);
        progImg[asmPc] = {f, op};
        asmPc          = asmPc + 8'd1;
    endtask

    task automatic emitArg(input opcodeT op, input byteT arg, input logic [3:0] f = 4'h0);
        emitOp(op, f);
        progImg[asmPc] = arg;
        asmPc          = asmPc + 8'd1;
    endtask

    task automatic fillRam();
        for (int i = 0; i < window; i++)
            ramExp[i] = byteT'($urandom);
    endtask

    task automatic loadRam();
        for (int i = 0; i < window; i++)
            apbWrite(hostAddrWidth'(i), ramExp[i]);   // Bit 8 low, data RAM
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progSpan; i++)
            apbWrite({1'b1, byteT'(i)}, progImg[i]);
        apbWrite({1'b1, vectorLine1}, progImg[vectorLine1]);
        apbWrite({1'b1, vectorLine0}, progImg[vectorLine0]);
    endtask

    task automatic compareRam(input string name);
        byteT rd;
        for (int i = 0; i < window; i++) begin
            apbRead(hostAddrWidth'(i), rd);
            checkByte($sformatf("%s ram[%02h]", name, i), ramExp[i], rd);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Interrupt threads

    task automatic startThread(input logic [1:0] lines, input logic [1:0] expAck,
                               input string name);
        @(posedge CLK);
        #1;
        ackPulses = 0;
        irqRaise  = lines;
        @(negedge CLK);
        while (irqAck == 2'b00)
            @(negedge CLK);
        checkAck(name, expAck, irqAck);
        if (!threadActive) begin
            $display("%s: threadActive did not rise with the acknowledge", name);
            otherErrors++;
        end
        @(posedge CLK);
        #1;
        irqRaise = 2'b00;
    endtask

    task automatic finishThread(input string name);
        int waited;
        waited = 0;
        while (threadActive && waited < threadLimit) begin
            @(negedge CLK);
            waited++;
        end
        if (threadActive) begin
            $display("%s: thread never fell back to idle", name);
            otherErrors++;
        end
        if (ackPulses != 1) begin
            $display("%s: acknowledge was high for %0d cycles, not one", name, ackPulses);
            otherErrors++;
        end
    endtask

    task automatic runThread(input logic [1:0] lines, input logic [1:0] expAck,
                             input byteT vector, input string name);
        startThread(lines, expAck, name);
        finishThread(name);
        ramExp = runIsa(progImg, ramExp, vector);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests

    initial begin
        byteT loop;
        byteT rd;
        void'($urandom(32'h1140_1127));     // Single seed for the run
        CLK      = 1'b0;
        RESET    = 1'b1;
        pSel     = 1'b0;
        pEnable  = 1'b0;
        pWrite   = 1'b0;
        pAddr    = '0;
        pWData   = '0;
        irqRaise = 2'b00;
        repeat (8) @(posedge CLK);
        #1;
        RESET = 1'b0;
        @(negedge CLK);
        checkAck("reset", 2'b00, irqAck);
        if (threadActive || pReady) begin
            $display("reset: threadActive or pReady is high after reset");
            otherErrors++;
        end

        // Swap two bytes through A and B
        newProgram();
        fillRam();
        emitArg(opReadA, 8'h10);
        emitArg(opReadB, 8'h11);
        emitArg(opWriteA, 8'h11);
        emitArg(opWriteB, 8'h10);
        emitOp(opIdle);
        progImg[vectorLine0] = 8'h00;
        loadRam();
        loadProgram();
        runThread(2'b01, 2'b01, vectorLine0, "move");
        compareRam("move");

        // Every ALU code plus one unused, alternating A and B forms
        newProgram();
        fillRam();
        for (int i = 0; i < 13; i++) begin
            emitArg(opReadA, 8'h20);
            emitArg(opReadB, 8'h21);
            if (i % 2) begin
                emitOp(opAluB, i[3:0]);
                emitArg(opWriteB, byteT'(8'h30 + i));
            end else begin
                emitOp(opAluA, i[3:0]);
                emitArg(opWriteA, byteT'(8'h30 + i));
            end
        end
        emitOp(opIdle);
        progImg[vectorLine0] = 8'h00;
        loadRam();
        loadProgram();
        runThread(2'b01, 2'b01, vectorLine0, "alu");
        compareRam("alu");

        // Counting loop, goto over idle bytes, call and return
        newProgram();
        fillRam();
        ramExp[1] = byteT'($urandom & 7);          // Start count
        ramExp[2] = byteT'(8 + ($urandom & 7));    // Limit
        emitArg(opGoto, 8'h10);
        asmPc = 8'h10;
        emitArg(opReadA, 8'h01);
        emitArg(opReadB, 8'h02);
        loop = asmPc;
        emitOp(opAluA, aluIncA);
        emitArg(opWriteA, 8'h03);
        emitArg(opBranch, loop, aluLt);            // Loop while A < B
        emitArg(opCall, 8'h40);
        emitArg(opWriteB, 8'h05);
        emitOp(opIdle);
        asmPc = 8'h40;                             // Subroutine
        emitOp(opAluB, aluIncB);
        emitArg(opWriteB, 8'h04);
        emitOp(opReturn);
        progImg[vectorLine0] = 8'h00;
        loadRam();
        loadProgram();
        runThread(2'b01, 2'b01, vectorLine0, "control");
        compareRam("control");

        // Pointers into the upper half of the window
        newProgram();
        fillRam();
        ramExp[6] = 8'h20 | byteT'($urandom & 8'h1F);
        ramExp[7] = 8'h20 | byteT'($urandom & 8'h1F);
        emitArg(opReadA, 8'h06);
        emitOp(opDerefA);
        emitArg(opReadB, 8'h07);
        emitOp(opDerefB);
        emitArg(opWriteA, 8'h08);
        emitArg(opWriteB, 8'h09);
        emitOp(opIdle);
        progImg[vectorLine0] = 8'h00;
        loadRam();
        loadProgram();
        runThread(2'b01, 2'b01, vectorLine0, "deref");
        compareRam("deref");

        // Line 1 thread at 00, line 0 thread at 20
        newProgram();
        fillRam();
        emitArg(opReadA, 8'h0A);
        emitOp(opAluA, aluIncA);
        emitArg(opWriteA, 8'h0B);
        emitOp(opIdle);
        asmPc = 8'h20;
        emitArg(opReadB, 8'h0A);
        emitOp(opAluB, aluDecB);
        emitArg(opWriteB, 8'h0C);
        emitOp(opIdle);
        progImg[vectorLine1] = 8'h00;
        progImg[vectorLine0] = 8'h20;
        loadRam();
        loadProgram();
        runThread(2'b10, 2'b10, vectorLine1, "irq line 1");
        runThread(2'b11, 2'b01, vectorLine0, "irq both");   // Line 0 wins
        compareRam("irq order");

        // Host reads compete with the running thread
        startThread(2'b10, 2'b10, "irq overlap");
        for (int i = 8'h30; i < 8'h34; i++) begin
            apbRead(hostAddrWidth'(i), rd);
            checkByte($sformatf("host read ram[%02h]", i), ramExp[i], rd);
        end
        finishThread("irq overlap");
        ramExp = runIsa(progImg, ramExp, vectorLine1);
        compareRam("irq overlap");

        $display("Errors: data %0d, ack %0d, other %0d", dataErrors, ackErrors, otherErrors);
        if (dataErrors + ackErrors + otherErrors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+testbench
src/cpuPkg.sv
src/memBusIf.sv
src/aluUnit.sv
src/cpuCore.sv
src/hostPort.sv
src/busArbiter.sv
src/dataRam.sv
src/progMem.sv
src/cpuSystem.sv
testbench/tbCpuSystem.sv
